//--- verilog/resp_consts.svh
/*
  Response subsystem constants
  Widths of the host bus response fields, the tag table depth
  and the parity sense of the response tag
*/
`ifndef RESP_CONSTS_SVH
`define RESP_CONSTS_SVH

// Response tag and table depth
`define TAG_BITS 8
`define TAG_ENTRIES (1 << `TAG_BITS)

// Response payload fields
`define CREDIT_BITS 9
`define RESP_CODE_BITS 8

// Error vector, checker part excludes the unknown tag bit
`define ERR_BITS 8
`define CHECK_ERR_BITS (`ERR_BITS - 1)

// Tag plus parity bit holds an odd number of ones
`define ODD_PARITY 1'b1

`endif

//--- verilog/psl_pkg.sv
/*
  Host bus side types
  Response codes returned by the coherent bus and the bit
  positions of the response error vector
*/
`include "resp_consts.svh"

package psl_pkg;

  ////////////////////////////////////////
  // Response codes
  ////////////////////////////////////////

  // Codes outside this list count as FAILED
  typedef enum logic [`RESP_CODE_BITS-1:0] {
    RESP_DONE    = 8'd0,
    RESP_AERROR  = 8'd1,
    RESP_DERROR  = 8'd3,
    RESP_NLOCK   = 8'd4,
    RESP_NRES    = 8'd5,
    RESP_FLUSHED = 8'd6,
    RESP_FAULT   = 8'd7,
    RESP_FAILED  = 8'd8,
    RESP_PAGED   = 8'd10
  } resp_code_t;

  ////////////////////////////////////////
  // Error vector bit positions
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    ERR_FAILED      = 3'd0,
    ERR_PAGED       = 3'd1,
    ERR_FAULT       = 3'd2,
    ERR_NLOCK_NRES  = 3'd3,
    ERR_DERROR      = 3'd4,
    ERR_AERROR      = 3'd5,
    ERR_TAG_PARITY  = 3'd6,
    ERR_UNKNOWN_TAG = 3'd7
  } err_bit_e;

endpackage

//--- verilog/afu_pkg.sv
/*
  Function unit side types
  Command types issued by the unit and the state of each
  tag slot in the outstanding command table
*/
package afu_pkg;

  ////////////////////////////////////////
  // Command types
  ////////////////////////////////////////

  // CMD_NONE marks a tag with no command on record
  typedef enum logic [2:0] {
    CMD_NONE           = 3'd0,
    CMD_READ           = 3'd1,
    CMD_WRITE          = 3'd2,
    CMD_WED            = 3'd3,
    CMD_RESTART        = 3'd4,
    CMD_PREFETCH_READ  = 3'd5,
    CMD_PREFETCH_WRITE = 3'd6
  } cmd_type_t;

  ////////////////////////////////////////
  // Tag slot state
  ////////////////////////////////////////

  typedef enum logic {
    SLOT_FREE = 1'b0,
    SLOT_BUSY = 1'b1
  } slot_state_t;

endpackage

//--- verilog/resp_ifs.sv
/*
  Response subsystem interfaces
  Raw response from the host bus, tag table lookup result
  and checker result, each with its producer and consumer views
*/
`timescale 1ns/1ps
`include "resp_consts.svh"

// Response as sampled from the host bus
interface resp_bus_if;
  logic                        valid;
  logic [`TAG_BITS-1:0]        tag;
  logic                        tag_parity;
  logic [`RESP_CODE_BITS-1:0]  code;
  logic [`CREDIT_BITS-1:0]     credits;

  modport checker_side (input valid, input tag, input tag_parity, input code, input credits);
  // Table only needs to know which tag came back
  modport table_side (input valid, input tag);
endinterface

// Stored command type for the returned tag, one cycle later
interface tag_lookup_if import afu_pkg::*; ();
  logic                 valid;
  logic [`TAG_BITS-1:0] tag;
  cmd_type_t            cmd_type;
  logic                 unknown;

  modport table_side (output valid, output tag, output cmd_type, output unknown);
  modport router (input valid, input tag, input cmd_type, input unknown);
endinterface

// Registered response with parity and code error bits
interface resp_check_if;
  logic                        valid;
  logic [`TAG_BITS-1:0]        tag;
  logic [`RESP_CODE_BITS-1:0]  code;
  logic [`CREDIT_BITS-1:0]     credits;
  logic [`CHECK_ERR_BITS-1:0]  errors;

  modport checker_side (output valid, output tag, output code, output credits, output errors);
  modport router (input valid, input tag, input code, input credits, input errors);
endinterface

//--- verilog/tag_table.sv
/*
  Outstanding command table
  Keeps the command type of every issued tag, looks it up when
  the response returns and frees the slot. Result is registered
  one cycle after the response
*/
`timescale 1ns/1ps
`include "resp_consts.svh"

module tag_table import afu_pkg::*; (
  input  logic                 clock,
  input  logic                 rstn,
  input  logic                 cmd_issue,
  input  logic [`TAG_BITS-1:0] cmd_tag,
  input  cmd_type_t            cmd_type,
  resp_bus_if.table_side       bus,
  tag_lookup_if.table_side     lookup
);

  slot_state_t slot_state [`TAG_ENTRIES];
  cmd_type_t   slot_type  [`TAG_ENTRIES];

  ////////////////////////////////////////
  // Slot state
  ////////////////////////////////////////

  // Release first so a new issue on the same edge wins
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < `TAG_ENTRIES; i++) begin
        slot_state[i] <= SLOT_FREE;
      end
    end else begin
      if (bus.valid) begin
        slot_state[bus.tag] <= SLOT_FREE;
      end
      if (cmd_issue) begin
        slot_state[cmd_tag] <= SLOT_BUSY;
      end
    end
  end

  // Command type store
  always_ff @(posedge clock) begin
    if (cmd_issue) begin
      slot_type[cmd_tag] <= cmd_type;
    end
  end

  ////////////////////////////////////////
  // Lookup result
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      lookup.valid <= 1'b0;
    end else begin
      lookup.valid <= bus.valid;
    end
  end

  // FREE slot means no command is on record for this tag
  always_ff @(posedge clock) begin
    if (bus.valid) begin
      lookup.tag <= bus.tag;
      if (slot_state[bus.tag] == SLOT_BUSY) begin
        lookup.cmd_type <= slot_type[bus.tag];
        lookup.unknown  <= 1'b0;
      end else begin
        lookup.cmd_type <= CMD_NONE;
        lookup.unknown  <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/response_checker.sv
/*
  Response checker
  Checks the odd parity of the response tag and sorts the
  response code into error bits. One register stage, aligned
  with the tag table lookup
*/
`timescale 1ns/1ps
`include "resp_consts.svh"

module response_checker import psl_pkg::*; (
  input  logic               clock,
  input  logic               rstn,
  resp_bus_if.checker_side   bus,
  resp_check_if.checker_side check
);

  logic                       parity_calc;
  logic                       parity_error;
  logic [`CHECK_ERR_BITS-1:0] code_errs;

  ////////////////////////////////////////
  // Response code classification
  ////////////////////////////////////////

  function automatic logic [`CHECK_ERR_BITS-1:0] code_errors(
    input logic [`RESP_CODE_BITS-1:0] code
  );
    logic [`CHECK_ERR_BITS-1:0] errs;
    errs = '0;
    case (code)
      RESP_DONE,
      RESP_FLUSHED: begin
        // Normal completion
        errs = '0;
      end
      RESP_AERROR: errs[ERR_AERROR]     = 1'b1;
      RESP_DERROR: errs[ERR_DERROR]     = 1'b1;
      RESP_NLOCK,
      RESP_NRES:   errs[ERR_NLOCK_NRES] = 1'b1;
      RESP_FAULT:  errs[ERR_FAULT]      = 1'b1;
      RESP_PAGED:  errs[ERR_PAGED]      = 1'b1;
      RESP_FAILED: errs[ERR_FAILED]     = 1'b1;
      // Undefined codes are treated as failed
      default:     errs[ERR_FAILED]     = 1'b1;
    endcase
    return errs;
  endfunction

  ////////////////////////////////////////
  // Tag parity
  ////////////////////////////////////////

  // Parity bit that makes tag plus parity odd
  assign parity_calc  = (^bus.tag) ^ `ODD_PARITY;
  assign parity_error = parity_calc ^ bus.tag_parity;

  always_comb begin
    code_errs                 = code_errors(bus.code);
    code_errs[ERR_TAG_PARITY] = parity_error;
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      check.valid <= 1'b0;
    end else begin
      check.valid <= bus.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (bus.valid) begin
      check.tag     <= bus.tag;
      check.code    <= bus.code;
      check.credits <= bus.credits;
      check.errors  <= code_errs;
    end
  end

endmodule

//--- verilog/response_router.sv
/*
  Response router
  Combines the tag lookup and the checker result into one pulse
  per command class, a registered response payload and the error
  vector. Everything is gated by the registered enable
*/
`timescale 1ns/1ps
`include "resp_consts.svh"

module response_router import psl_pkg::*, afu_pkg::*; (
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        enabled_in,
  tag_lookup_if.router                lookup,
  resp_check_if.router                check,
  output logic                        read_response,
  output logic                        write_response,
  output logic                        wed_response,
  output logic                        restart_response,
  output logic                        prefetch_read_response,
  output logic                        prefetch_write_response,
  output logic                        resp_out_valid,
  output logic [`TAG_BITS-1:0]        resp_out_tag,
  output logic [`RESP_CODE_BITS-1:0]  resp_out_code,
  output logic [`CREDIT_BITS-1:0]     resp_out_credits,
  output cmd_type_t                   resp_out_cmd_type,
  output logic [`ERR_BITS-1:0]        resp_error
);

  logic                 enabled;
  logic                 route;
  logic [5:0]           class_hit;
  logic [`ERR_BITS-1:0] err_vec;

  ////////////////////////////////////////
  // Enable register
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;
    end
  end

  assign route = enabled & check.valid;

  ////////////////////////////////////////
  // Class select and error vector
  ////////////////////////////////////////

  // Bit order is read, write, wed, restart, prefetch read, prefetch write
  always_comb begin
    class_hit = 6'b000000;
    case (lookup.cmd_type)
      CMD_READ:           class_hit[0] = 1'b1;
      CMD_WRITE:          class_hit[1] = 1'b1;
      CMD_WED:            class_hit[2] = 1'b1;
      CMD_RESTART:        class_hit[3] = 1'b1;
      CMD_PREFETCH_READ:  class_hit[4] = 1'b1;
      CMD_PREFETCH_WRITE: class_hit[5] = 1'b1;
      default:            class_hit    = 6'b000000;
    endcase
  end

  always_comb begin
    err_vec                     = '0;
    err_vec[ERR_TAG_PARITY:0]   = check.errors;
    err_vec[ERR_UNKNOWN_TAG]    = lookup.unknown;
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  // Outputs last one cycle and clear when nothing is routed
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      {prefetch_write_response, prefetch_read_response, restart_response,
       wed_response, write_response, read_response} <= 6'b000000;
      resp_out_valid    <= 1'b0;
      resp_out_tag      <= '0;
      resp_out_code     <= '0;
      resp_out_credits  <= '0;
      resp_out_cmd_type <= CMD_NONE;
      resp_error        <= '0;
    end else if (route) begin
      {prefetch_write_response, prefetch_read_response, restart_response,
       wed_response, write_response, read_response} <= class_hit;
      resp_out_valid    <= 1'b1;
      resp_out_tag      <= check.tag;
      resp_out_code     <= check.code;
      resp_out_credits  <= check.credits;
      resp_out_cmd_type <= lookup.cmd_type;
      resp_error        <= err_vec;
    end else begin
      {prefetch_write_response, prefetch_read_response, restart_response,
       wed_response, write_response, read_response} <= 6'b000000;
      resp_out_valid    <= 1'b0;
      resp_out_tag      <= '0;
      resp_out_code     <= '0;
      resp_out_credits  <= '0;
      resp_out_cmd_type <= CMD_NONE;
      resp_error        <= '0;
    end
  end

endmodule

//--- verilog/response_top.sv
/*
  Response subsystem top level
  Plain host bus and command issue ports in, routed class pulses,
  payload and error vector out. Two cycles from response to output
*/
`timescale 1ns/1ps
`include "resp_consts.svh"

module response_top import afu_pkg::*; (
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        enabled_in,
  // Command issue strobe
  input  logic                        cmd_issue,
  input  logic [`TAG_BITS-1:0]        cmd_tag,
  input  cmd_type_t                   cmd_type,
  // Host bus response
  input  logic                        resp_valid,
  input  logic [`TAG_BITS-1:0]        resp_tag,
  input  logic                        resp_tag_parity,
  input  logic [`RESP_CODE_BITS-1:0]  resp_code,
  input  logic [`CREDIT_BITS-1:0]     resp_credits,
  // Routed result
  output logic                        read_response,
  output logic                        write_response,
  output logic                        wed_response,
  output logic                        restart_response,
  output logic                        prefetch_read_response,
  output logic                        prefetch_write_response,
  output logic                        resp_out_valid,
  output logic [`TAG_BITS-1:0]        resp_out_tag,
  output logic [`RESP_CODE_BITS-1:0]  resp_out_code,
  output logic [`CREDIT_BITS-1:0]     resp_out_credits,
  output cmd_type_t                   resp_out_cmd_type,
  output logic [`ERR_BITS-1:0]        resp_error
);

  resp_bus_if   u_bus ();
  tag_lookup_if u_lookup ();
  resp_check_if u_check ();

  // Host bus into the shared response interface
  assign u_bus.valid      = resp_valid;
  assign u_bus.tag        = resp_tag;
  assign u_bus.tag_parity = resp_tag_parity;
  assign u_bus.code       = resp_code;
  assign u_bus.credits    = resp_credits;

  ////////////////////////////////////////
  // Stage 1 table lookup and check
  ////////////////////////////////////////

  tag_table u_tag_table (
    .clock     (clock),
    .rstn      (rstn),
    .cmd_issue (cmd_issue),
    .cmd_tag   (cmd_tag),
    .cmd_type  (cmd_type),
    .bus       (u_bus.table_side),
    .lookup    (u_lookup.table_side)
  );

  response_checker u_response_checker (
    .clock (clock),
    .rstn  (rstn),
    .bus   (u_bus.checker_side),
    .check (u_check.checker_side)
  );

  ////////////////////////////////////////
  // Stage 2 routing
  ////////////////////////////////////////

  response_router u_response_router (
    .clock                   (clock),
    .rstn                    (rstn),
    .enabled_in              (enabled_in),
    .lookup                  (u_lookup.router),
    .check                   (u_check.router),
    .read_response           (read_response),
    .write_response          (write_response),
    .wed_response            (wed_response),
    .restart_response        (restart_response),
    .prefetch_read_response  (prefetch_read_response),
    .prefetch_write_response (prefetch_write_response),
    .resp_out_valid          (resp_out_valid),
    .resp_out_tag            (resp_out_tag),
    .resp_out_code           (resp_out_code),
    .resp_out_credits        (resp_out_credits),
    .resp_out_cmd_type       (resp_out_cmd_type),
    .resp_error              (resp_error)
  );

endmodule

//--- tb/tb_clock_gen.sv
/*
  Testbench clock and reset
  20 ns clock, active low reset held for 10 cycles
*/
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic rstn
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Release just after an edge, clear of the sampling point
  initial begin
    rstn = 1'b0;
    repeat (10) @(posedge clock);
    #2;
    rstn = 1'b1;
  end

endmodule

//--- tb/response_tb.sv
/*
  Response subsystem testbench
  Drives tag issue and host bus responses into the DUT, keeps a
  model of outstanding tags and checks every output cycle against
  the expected result two edges after each sampled response
*/
`timescale 1ns/1ps
`include "resp_consts.svh"

module response_tb import psl_pkg::*, afu_pkg::*; ();

  // Upper bound on driven cycles for the watchdog
  localparam int NUM_OPS    = 100;
  localparam int TIMEOUT_NS = (10 + NUM_OPS * 4 + 50) * 20;

  typedef struct packed {
    logic                       valid;
    logic [5:0]                 pulses;
    logic [`TAG_BITS-1:0]       tag;
    logic [`RESP_CODE_BITS-1:0] code;
    logic [`CREDIT_BITS-1:0]    credits;
    cmd_type_t                  cmd_type;
    logic [`ERR_BITS-1:0]       error;
  } expect_t;

  logic clock, rstn, enabled_in, cmd_issue, resp_valid, resp_tag_parity;
  logic [`TAG_BITS-1:0]       cmd_tag, resp_tag, resp_out_tag;
  cmd_type_t                  cmd_type, resp_out_cmd_type;
  logic [`RESP_CODE_BITS-1:0] resp_code, resp_out_code;
  logic [`CREDIT_BITS-1:0]    resp_credits, resp_out_credits;
  logic [`ERR_BITS-1:0]       resp_error;
  logic read_response, write_response, wed_response, restart_response;
  logic prefetch_read_response, prefetch_write_response, resp_out_valid;

  slot_state_t model_state [`TAG_ENTRIES];
  cmd_type_t   model_type  [`TAG_ENTRIES];
  expect_t     exp_q [$];
  expect_t     chk;
  logic        enable_req;
  integer      seed   = 32'hcd8c_5f68;
  int          errors = 0;
  int          checks = 0;

  tb_clock_gen u_clock_gen (.clock(clock), .rstn(rstn));

  response_top u_dut (.*);

  ////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////

  // Undefined codes count as FAILED
  function automatic logic [`ERR_BITS-1:0] code_error_bits(input logic [7:0] code);
    logic [`ERR_BITS-1:0] v;
    v = '0;
    if (code == RESP_AERROR) v[ERR_AERROR] = 1'b1;
    else if (code == RESP_DERROR) v[ERR_DERROR] = 1'b1;
    else if (code == RESP_NLOCK || code == RESP_NRES) v[ERR_NLOCK_NRES] = 1'b1;
    else if (code == RESP_FAULT) v[ERR_FAULT] = 1'b1;
    else if (code == RESP_PAGED) v[ERR_PAGED] = 1'b1;
    else if (code != RESP_DONE && code != RESP_FLUSHED) v[ERR_FAILED] = 1'b1;
    return v;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("Mismatch %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  // Every DUT output against one expected result
  task automatic compare_outputs(input expect_t e);
    compare("resp_out_valid", e.valid, resp_out_valid);
    compare("class_pulses", e.pulses, {prefetch_write_response,
            prefetch_read_response, restart_response, wed_response,
            write_response, read_response});
    compare("resp_out_tag", e.tag, resp_out_tag);
    compare("resp_out_code", e.code, resp_out_code);
    compare("resp_out_credits", e.credits, resp_out_credits);
    compare("resp_out_cmd_type", e.cmd_type, resp_out_cmd_type);
    compare("resp_error", e.error, resp_error);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // One clock cycle of inputs plus the result expected for it
  task automatic drive_cycle(input logic issue, input logic [7:0] itag,
                             input cmd_type_t itype, input logic rv,
                             input logic [7:0] rtag, input logic bad_par,
                             input logic [7:0] rcode, input logic [8:0] rcred);
    expect_t e;
    @(posedge clock);
    #2;
    enabled_in      = enable_req;
    cmd_issue       = issue;
    cmd_tag         = itag;
    cmd_type        = itype;
    resp_valid      = rv;
    resp_tag        = rtag;
    resp_tag_parity = (~^rtag) ^ bad_par;
    resp_code       = rcode;
    resp_credits    = rcred;
    e = '0;
    if (rv && enable_req) begin
      e.valid   = 1'b1;
      e.tag     = rtag;
      e.code    = rcode;
      e.credits = rcred;
      e.error   = code_error_bits(rcode);
      // Tag and parity together must hold an odd number of ones
      if (~^{rtag, resp_tag_parity}) e.error[ERR_TAG_PARITY] = 1'b1;
      if (model_state[rtag] == SLOT_BUSY) begin
        e.cmd_type = model_type[rtag];
        e.pulses   = 6'b000001 << (model_type[rtag] - 1);
      end else begin
        e.error[ERR_UNKNOWN_TAG] = 1'b1;
      end
    end
    // Slot is freed even when routing is disabled
    if (rv) model_state[rtag] = SLOT_FREE;
    if (issue) begin
      model_state[itag] = SLOT_BUSY;
      model_type[itag]  = itype;
    end
    exp_q.push_back(e);
  endtask

  task automatic issue_cmd(input logic [7:0] tag, input cmd_type_t t);
    drive_cycle(1'b1, tag, t, 1'b0, 8'h00, 1'b0, 8'h00, 9'h000);
  endtask

  task automatic send_resp(input logic [7:0] tag, input logic [7:0] code,
                           input logic bad_par);
    logic [8:0] cred;
    cred = $random(seed);
    drive_cycle(1'b0, 8'h00, CMD_NONE, 1'b1, tag, bad_par, code, cred);
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, 8'h00, CMD_NONE, 1'b0, 8'h00, 1'b0, 8'h00, 9'h000);
  endtask

  ////////////////////////////////////////
  // Output check two edges after each input
  ////////////////////////////////////////

  always @(negedge clock) begin
    if (exp_q.size() > 2) begin
      chk = exp_q.pop_front();
      compare_outputs(chk);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns with responses still pending", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [7:0] codes [10];
    logic [7:0] rand_tags [16];
    logic [7:0] rnd;
    codes = '{8'd0, 8'd1, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8, 8'd10, 8'h2b};
    enable_req = 1'b0;
    enabled_in = 1'b0;
    cmd_issue = 1'b0;
    cmd_tag = '0;
    cmd_type = CMD_NONE;
    resp_valid = 1'b0;
    resp_tag = '0;
    resp_tag_parity = 1'b0;
    resp_code = '0;
    resp_credits = '0;
    for (int i = 0; i < `TAG_ENTRIES; i++) model_state[i] = SLOT_FREE;
    @(posedge rstn);
    // No edge has passed since reset, so outputs show their reset values
    compare_outputs('0);
    // Quiet outputs before routing is enabled
    idle(3);
    enable_req = 1'b1;
    idle(2);
    // Every command class answered with DONE
    for (int t = 1; t <= 6; t++) issue_cmd(8'h10 + t, cmd_type_t'(t));
    for (int t = 1; t <= 6; t++) send_resp(8'h10 + t, RESP_DONE, 1'b0);
    // Every response code plus one undefined code
    for (int i = 0; i < 10; i++) begin
      issue_cmd(8'h20 + i, CMD_READ);
      send_resp(8'h20 + i, codes[i], 1'b0);
    end
    // Bad tag parity keeps the stored class
    issue_cmd(8'h40, CMD_WRITE);
    send_resp(8'h40, RESP_DONE, 1'b1);
    // Never issued tag and a second answer
    send_resp(8'hf0, RESP_DONE, 1'b0);
    send_resp(8'h11, RESP_DONE, 1'b0);
    // Disabled responses still free their tags
    issue_cmd(8'h50, CMD_WED);
    issue_cmd(8'h51, CMD_READ);
    enable_req = 1'b0;
    idle(1);
    send_resp(8'h50, RESP_DONE, 1'b0);
    send_resp(8'h51, RESP_PAGED, 1'b0);
    enable_req = 1'b1;
    idle(1);
    send_resp(8'h50, RESP_DONE, 1'b0);
    // Random issue followed by back to back responses
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      rand_tags[i] = {1'b1, i[3:0], rnd[2:0]};
      issue_cmd(rand_tags[i], cmd_type_t'(1 + ($unsigned($random(seed)) % 6)));
    end
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      send_resp(rand_tags[i], rnd[7] ? RESP_DONE : codes[rnd[3:0] % 10], rnd[6:4] == 3'd0);
    end
    idle(4);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+verilog
verilog/psl_pkg.sv
verilog/afu_pkg.sv
verilog/resp_ifs.sv
verilog/tag_table.sv
verilog/response_checker.sv
verilog/response_router.sv
verilog/response_top.sv
tb/tb_clock_gen.sv
tb/response_tb.sv
